//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [isaPkg::dataWidth-1:0] a,
	input  logic [isaPkg::dataWidth-1:0] b,
	input  isaPkg::opcode_t op,
	output logic [isaPkg::dataWidth-1:0] result,
	output logic zero,
	output logic carry,
	output logic negative
);
	import isaPkg::*;

	// Extra top bit holds carry out or borrow
	logic [dataWidth:0] wide;

	always_comb begin
		case (op)
			ADD: wide = {1'b0, a} + {1'b0, b};
			SUB: wide = {1'b0, a} - {1'b0, b};
			INC: wide = {1'b0, a} + 1'b1;
			DEC: wide = {1'b0, a} - 1'b1;
			AND: wide = {1'b0, a & b};
			OR:  wide = {1'b0, a | b};
			XOR: wide = {1'b0, a ^ b};
			// Pass b for register moves and immediates
			MOV, LDI: wide = {1'b0, b};
			default: wide = '0;
		endcase
	end

	assign result = wide[dataWidth-1:0];
	assign carry = wide[dataWidth];
	assign zero = (result == '0);
	assign negative = result[dataWidth-1];

endmodule

//--- hdl/busPkg.sv
package busPkg;

	// One write into program RAM during the load phase
	typedef struct packed {
		logic we;
		logic [isaPkg::progAddrWidth-1:0] addr;
		logic [isaPkg::instrWidth-1:0] data;
	} progWrite_t;

	typedef enum logic {
		seq  = 1'b0,
		jump = 1'b1
	} pcSel_t;

	// Decoder output bundle
	typedef struct packed {
		isaPkg::opcode_t aluOp;
		logic useImm;
		logic regWe;
		isaPkg::regIdx_t dest;
		logic memRead;
		logic memWrite;
		logic outReq;
		logic flagWe;
		logic halt;
		pcSel_t pcSel;
	} ctrl_t;

	// Load waiting one cycle for data RAM
	typedef struct packed {
		logic valid;
		isaPkg::regIdx_t dest;
	} pendLoad_t;

endpackage

//--- hdl/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
	input  isaPkg::instr_u instr,
	input  logic zeroFlag,
	output busPkg::ctrl_t ctrl
);
	import isaPkg::*;
	import busPkg::*;

	opcode_t op;

	// Both formats keep the opcode in the same place
	assign op = instr.r.opcode;

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = op;
		ctrl.dest = instr.r.dest;
		ctrl.pcSel = seq;

		case (op)
			ADD, SUB, AND, OR, XOR, INC, DEC: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			MOV: begin
				ctrl.regWe = 1'b1;
			end
			LDI: begin
				ctrl.regWe = 1'b1;
				ctrl.useImm = 1'b1;
			end
			// Load data comes back through write port B next cycle
			LD: begin
				ctrl.memRead = 1'b1;
			end
			ST: begin
				ctrl.memWrite = 1'b1;
			end
			OUT: begin
				ctrl.outReq = 1'b1;
			end
			JMP: begin
				ctrl.pcSel = jump;
			end
			JZ: begin
				if (zeroFlag) begin
					ctrl.pcSel = jump;
				end
			end
			HALT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
				// NOP
			end
		endcase
	end

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic clk,
	input  logic rstN,
	input  logic run,
	input  busPkg::progWrite_t prog,
	output logic ioReq,
	output logic [isaPkg::dataWidth-1:0] ioData,
	input  logic ioAck,
	output logic halted
);
	import isaPkg::*;
	import busPkg::*;

	logic [progAddrWidth-1:0] pc;
	logic [progAddrWidth-1:0] nextPc;
	instr_u instr;
	ctrl_t ctrl;
	pendLoad_t pend;
	logic issue;
	logic busy;
	logic loadIssue;
	logic zeroFlag;
	logic aluZero;
	logic [dataWidth-1:0] rawA;
	logic [dataWidth-1:0] rawB;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] readData;

	// Nothing commits while loading, stalled on the port or halted
	assign issue = run && !halted && !busy;
	assign loadIssue = issue && ctrl.memRead;

	assign nextPc = (ctrl.pcSel == jump) ? instr.i.imm[progAddrWidth-1:0] : pc + 1'b1;
	assign aluB = ctrl.useImm ? dataWidth'(instr.i.imm) : opB;

	//////////////////////////////////////////////////
	// Program counter, flags and halt
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halted <= 1'b0;
			zeroFlag <= 1'b0;
		end else if (!run) begin
			pc <= '0;
		end else if (issue) begin
			if (ctrl.halt) begin
				halted <= 1'b1;
			end else begin
				pc <= nextPc;
			end
			if (ctrl.flagWe) begin
				zeroFlag <= aluZero;
			end
		end
	end

	controlDecoder decoder (.instr(instr), .zeroFlag(zeroFlag), .ctrl(ctrl));

	alu aluUnit (
		.a(opA), .b(aluB), .op(ctrl.aluOp), .result(aluResult),
		.zero(aluZero), .carry(), .negative()
	);

	registerFile regs (
		.clk(clk), .rstN(rstN), .rdA(instr.r.srcA), .rdB(instr.r.srcB),
		.dataA(rawA), .dataB(rawB),
		.weA(issue && ctrl.regWe), .wrA(ctrl.dest), .wdA(aluResult),
		.weB(pend.valid), .wrB(pend.dest), .wdB(readData)
	);

	pipelineRegister pipe (
		.clk(clk), .rstN(rstN), .issueLoad(loadIssue), .loadDest(ctrl.dest),
		.memData(readData), .rawA(rawA), .rawB(rawB),
		.srcA(instr.r.srcA), .srcB(instr.r.srcB), .opA(opA), .opB(opB), .pend(pend)
	);

	memoryController memCtrl (
		.clk(clk), .rstN(rstN), .prog(prog), .pc(pc), .instr(instr),
		.dataAddr(opB[dataAddrWidth-1:0]), .memRead(loadIssue),
		.memWrite(issue && ctrl.memWrite), .writeData(opA), .readData(readData),
		.outReq(issue && ctrl.outReq), .busy(busy),
		.ioReq(ioReq), .ioData(ioData), .ioAck(ioAck)
	);

endmodule

//--- hdl/isaPkg.sv
package isaPkg;

	//////////////////////////////////////////////////
	// Machine widths
	//////////////////////////////////////////////////

	localparam int dataWidth = 16;
	localparam int instrWidth = 18;
	localparam int progAddrWidth = 8;
	localparam int dataAddrWidth = 8;

	typedef logic [3:0] regIdx_t;

	// Opcode occupies the top four bits in both formats
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		MOV  = 4'h5,
		LDI  = 4'h6,
		INC  = 4'h7,
		DEC  = 4'h8,
		LD   = 4'h9,
		ST   = 4'ha,
		OUT  = 4'hb,
		JMP  = 4'hc,
		JZ   = 4'hd,
		HALT = 4'he,
		NOP  = 4'hf
	} opcode_t;

	//////////////////////////////////////////////////
	// Instruction formats
	//////////////////////////////////////////////////

	// Register form
	typedef struct packed {
		opcode_t opcode;
		regIdx_t dest;
		regIdx_t srcA;
		regIdx_t srcB;
		logic [1:0] unused;
	} instrReg_t;

	// Immediate form, used by LDI, JMP and JZ
	typedef struct packed {
		opcode_t opcode;
		regIdx_t dest;
		logic [9:0] imm;
	} instrImm_t;

	typedef union packed {
		instrReg_t r;
		instrImm_t i;
	} instr_u;

endpackage

//--- hdl/memoryController.sv
`timescale 1ns/1ps

module memoryController (
	input  logic clk,
	input  logic rstN,
	input  busPkg::progWrite_t prog,
	input  logic [isaPkg::progAddrWidth-1:0] pc,
	output isaPkg::instr_u instr,
	input  logic [isaPkg::dataAddrWidth-1:0] dataAddr,
	input  logic memRead,
	input  logic memWrite,
	input  logic [isaPkg::dataWidth-1:0] writeData,
	output logic [isaPkg::dataWidth-1:0] readData,
	input  logic outReq,
	output logic busy,
	output logic ioReq,
	output logic [isaPkg::dataWidth-1:0] ioData,
	input  logic ioAck
);
	import isaPkg::*;

	typedef enum logic [1:0] {
		idle,
		waitAckHigh,
		waitAckLow
	} ioState_t;

	logic [instrWidth-1:0] progRam [2**progAddrWidth];
	logic [dataWidth-1:0] dataRam [2**dataAddrWidth];
	ioState_t state;

	//////////////////////////////////////////////////
	// Program RAM
	//////////////////////////////////////////////////

	// Written only from the load port
	always_ff @(posedge clk) begin
		if (prog.we) begin
			progRam[prog.addr] <= prog.data;
		end
	end

	// Asynchronous fetch
	assign instr = progRam[pc];

	//////////////////////////////////////////////////
	// Data RAM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (memWrite) begin
			dataRam[dataAddr] <= writeData;
		end
		if (memRead) begin
			readData <= dataRam[dataAddr];
		end
	end

	//////////////////////////////////////////////////
	// Output port handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (outReq) begin
						state <= waitAckHigh;
					end
				end
				waitAckHigh: begin
					if (ioAck) begin
						state <= waitAckLow;
					end
				end
				// Next request may start only once ack has dropped
				waitAckLow: begin
					if (!ioAck) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Held for the whole request
	always_ff @(posedge clk) begin
		if (state == idle && outReq) begin
			ioData <= writeData;
		end
	end

	assign ioReq = (state == waitAckHigh);
	assign busy = (state != idle);

endmodule

//--- hdl/pipelineRegister.sv
`timescale 1ns/1ps

module pipelineRegister (
	input  logic clk,
	input  logic rstN,
	input  logic issueLoad,
	input  isaPkg::regIdx_t loadDest,
	input  logic [isaPkg::dataWidth-1:0] memData,
	input  logic [isaPkg::dataWidth-1:0] rawA,
	input  logic [isaPkg::dataWidth-1:0] rawB,
	input  isaPkg::regIdx_t srcA,
	input  isaPkg::regIdx_t srcB,
	output logic [isaPkg::dataWidth-1:0] opA,
	output logic [isaPkg::dataWidth-1:0] opB,
	output busPkg::pendLoad_t pend
);

	logic hitA;
	logic hitB;

	// A new load replaces the one retiring this cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pend <= '0;
		end else begin
			pend.valid <= issueLoad;
			pend.dest <= loadDest;
		end
	end

	//////////////////////////////////////////////////
	// Forwarding of load data into operands
	//////////////////////////////////////////////////

	assign hitA = pend.valid && (pend.dest == srcA);
	assign hitB = pend.valid && (pend.dest == srcB);

	assign opA = hitA ? memData : rawA;
	assign opB = hitB ? memData : rawB;

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic clk,
	input  logic rstN,
	input  isaPkg::regIdx_t rdA,
	input  isaPkg::regIdx_t rdB,
	output logic [isaPkg::dataWidth-1:0] dataA,
	output logic [isaPkg::dataWidth-1:0] dataB,
	input  logic weA,
	input  isaPkg::regIdx_t wrA,
	input  logic [isaPkg::dataWidth-1:0] wdA,
	input  logic weB,
	input  isaPkg::regIdx_t wrB,
	input  logic [isaPkg::dataWidth-1:0] wdB
);
	import isaPkg::*;

	logic [dataWidth-1:0] regs [2**$bits(regIdx_t)];

	assign dataA = regs[rdA];
	assign dataB = regs[rdB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**$bits(regIdx_t); i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (weB) begin
				regs[wrB] <= wdB;
			end
			// Port A comes last so the younger write wins
			if (weA) begin
				regs[wrA] <= wdA;
			end
		end
	end

endmodule

//--- run.sh
#!/bin/bash
# Build and run cpuTb with Verilator, then check the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTb \
	-f sources.f -o cpuSim > build.log 2>&1 \
	&& ./obj_dir/cpuSim > sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sources.f
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/controlDecoder.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/pipelineRegister.sv
hdl/memoryController.sv
hdl/cpuTop.sv
verification/cpuTb.sv

//--- verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
	import isaPkg::*;
	import busPkg::*;

	localparam int haltLimit = 3000;
	localparam int ackLimit = 40;

	logic clk;
	logic rstN;
	logic run;
	progWrite_t prog;
	logic ioReq;
	logic [dataWidth-1:0] ioData;
	logic ioAck;
	logic halted;
	logic [31:0] lfsr = 32'h0d4e_d976;
	logic [instrWidth-1:0] image[$];
	logic [dataWidth-1:0] expected[$];
	logic prevReq;
	logic prevAck;
	logic [dataWidth-1:0] prevData;

	cpuTop DUT (
		.clk(clk), .rstN(rstN), .run(run), .prog(prog),
		.ioReq(ioReq), .ioData(ioData), .ioAck(ioAck), .halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic randomBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int ackDelay();
		logic [2:0] d;
		for (int i = 0; i < 3; i++) begin
			d[i] = randomBit();
		end
		return int'(d);
	endfunction

	function automatic logic [17:0] regWord(opcode_t op, int d, int a, int b);
		return {op, 4'(d), 4'(a), 4'(b), 2'b00};
	endfunction

	function automatic logic [17:0] immWord(opcode_t op, int d, int imm);
		return {op, 4'(d), 10'(imm)};
	endfunction

	//////////////////////////////////////////////////
	// Output port checks
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rstN) begin
			prevReq = 1'b0;
			prevAck = 1'b0;
		end else begin
			assert (run || (!ioReq && !halted))
				else abortRun("ioReq or halted went high while run was low");
			assert (!(halted && ioReq)) else abortRun("ioReq went high after HALT");
			assert (!(prevReq && ioReq) || ioData == prevData) else abortRun($sformatf(
				"ERROR ioData: got 0x%h, expected 0x%h while ioReq high", ioData, prevData));
			assert (!(prevReq && !ioReq) || prevAck)
				else abortRun("ioReq fell before ioAck was high");
			// New request, checked against the scoreboard
			if (!prevReq && ioReq) begin
				assert (!prevAck) else abortRun("ioReq rose before ioAck returned low");
				assert (expected.size() > 0) else abortRun("Output value sent with none expected");
				assert (ioData == expected[0]) else abortRun($sformatf(
					"ERROR ioData: got 0x%h, expected 0x%h", ioData, expected[0]));
				expected.pop_front();
			end
			prevReq = ioReq;
			prevAck = ioAck;
			prevData = ioData;
		end
	end

	// Ack side of the four-phase handshake
	initial begin : ackResponder
		int waited;
		ioAck = 1'b0;
		forever begin
			@(posedge clk);
			if (ioReq) begin
				repeat (ackDelay()) @(posedge clk);
				#2 ioAck = 1'b1;
				waited = 0;
				do begin
					@(posedge clk);
					waited++;
				end while (ioReq && waited < ackLimit);
				if (ioReq) abortRun("ioReq stayed high after ioAck was raised");
				repeat (ackDelay()) @(posedge clk);
				#2 ioAck = 1'b0;
			end
		end
	end

	task automatic runProgram();
		int waited;
		@(posedge clk);
		#2;
		rstN = 1'b0;
		run = 1'b0;
		repeat (8) @(posedge clk);
		#2 rstN = 1'b1;
		assert (!ioReq && !halted) else abortRun("ioReq or halted high after reset");
		foreach (image[i]) begin
			@(posedge clk);
			#2;
			prog.we = 1'b1;
			prog.addr = progAddrWidth'(i);
			prog.data = image[i];
		end
		@(posedge clk);
		#2;
		prog = '0;
		run = 1'b1;
		waited = 0;
		while (!halted && waited < haltLimit) begin
			@(posedge clk);
			waited++;
		end
		if (!halted) abortRun("Timed out waiting for halted");
		// Quiet window, no request may follow HALT
		repeat (20) @(posedge clk);
		image.delete();
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		prog = '0;

		//////////////////////////////////////////////////
		// Arithmetic, logic, branches and memory
		//////////////////////////////////////////////////

		image.push_back(immWord(LDI, 1, 'h0f5));
		image.push_back(immWord(LDI, 2, 'h03c));
		image.push_back(regWord(ADD, 3, 1, 2));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(SUB, 3, 1, 2));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(AND, 3, 1, 2));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(OR, 3, 1, 2));
		// Nonzero result, must fall through
		image.push_back(immWord(JZ, 0, 18));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(XOR, 3, 1, 2));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(MOV, 3, 0, 2));
		image.push_back(regWord(OUT, 0, 3, 0));
		image.push_back(regWord(SUB, 4, 1, 1));
		image.push_back(immWord(JZ, 0, 18));
		image.push_back(regWord(OUT, 0, 1, 0));
		image.push_back(regWord(DEC, 4, 4, 0));
		image.push_back(regWord(OUT, 0, 4, 0));
		image.push_back(regWord(INC, 4, 4, 0));
		image.push_back(regWord(OUT, 0, 4, 0));
		image.push_back(immWord(JMP, 0, 24));
		image.push_back(regWord(OUT, 0, 1, 0));
		image.push_back(regWord(ST, 0, 1, 2));
		image.push_back(regWord(ST, 0, 2, 1));
		image.push_back(regWord(LD, 5, 0, 2));
		image.push_back(regWord(OUT, 0, 5, 0));
		// Back to back loads
		image.push_back(regWord(LD, 6, 0, 2));
		image.push_back(regWord(LD, 7, 0, 1));
		image.push_back(regWord(ADD, 8, 6, 7));
		image.push_back(regWord(OUT, 0, 8, 0));
		image.push_back(regWord(HALT, 0, 0, 0));
		expected.push_back(16'h00f5 + 16'h003c);
		expected.push_back(16'h00f5 - 16'h003c);
		expected.push_back(16'h00f5 & 16'h003c);
		expected.push_back(16'h00f5 | 16'h003c);
		expected.push_back(16'h00f5 ^ 16'h003c);
		expected.push_back(16'h003c);
		expected.push_back(16'h0000 - 16'h0001);
		expected.push_back(16'hffff + 16'h0001);
		expected.push_back(16'h00f5);
		expected.push_back(16'h00f5 + 16'h003c);
		runProgram();

		// Countdown with DEC and JZ
		image.push_back(immWord(LDI, 1, 3));
		image.push_back(regWord(OUT, 0, 1, 0));
		image.push_back(regWord(DEC, 1, 1, 0));
		image.push_back(immWord(JZ, 0, 5));
		image.push_back(immWord(JMP, 0, 1));
		image.push_back(regWord(HALT, 0, 0, 0));
		for (int v = 3; v > 0; v--) begin
			expected.push_back(16'(v));
		end
		runProgram();

		if (expected.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			abortRun($sformatf("%0d expected output values never arrived", expected.size()));
		end
	end

endmodule
